/* design/riscv_priv_pkg.sv */
package riscv_priv_pkg;

    // privilege levels
    typedef logic [1:0] priv_t;

    localparam priv_t PRIV_USER       = 2'b00;
    localparam priv_t PRIV_SUPERVISOR = 2'b01;
    localparam priv_t PRIV_MACHINE    = 2'b11;  // 2'b10 is reserved

    // supervisor level CSRs
    localparam logic [11:0] CSR_SSTATUS  = 12'h100;  // view of mstatus
    localparam logic [11:0] CSR_STVEC    = 12'h105;
    localparam logic [11:0] CSR_SSCRATCH = 12'h140;
    localparam logic [11:0] CSR_SEPC     = 12'h141;
    localparam logic [11:0] CSR_SCAUSE   = 12'h142;
    localparam logic [11:0] CSR_STVAL    = 12'h143;
    localparam logic [11:0] CSR_SATP     = 12'h180;

    // machine level CSRs
    localparam logic [11:0] CSR_MSTATUS  = 12'h300;
    localparam logic [11:0] CSR_MISA     = 12'h301;
    localparam logic [11:0] CSR_MEDELEG  = 12'h302;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;
    localparam logic [11:0] CSR_MTVAL    = 12'h343;

    // read only user counters
    localparam logic [11:0] CSR_CYCLE    = 12'hc00;
    localparam logic [11:0] CSR_CYCLEH   = 12'hc80;

    // exception codes raised by this stage itself
    localparam logic [4:0] CAUSE_BREAKPOINT = 5'd3;
    localparam logic [4:0] CAUSE_ECALL_U    = 5'd8;
    localparam logic [4:0] CAUSE_ECALL_S    = 5'd9;
    localparam logic [4:0] CAUSE_ECALL_M    = 5'd11;

    // mstatus bit positions
    localparam int STATUS_SIE    = 1;
    localparam int STATUS_MIE    = 3;
    localparam int STATUS_SPIE   = 5;
    localparam int STATUS_MPIE   = 7;
    localparam int STATUS_SPP    = 8;
    localparam int STATUS_MPP_LO = 11;  // MPP is two bits wide

    // misa
    localparam int MISA_C = 2;

    localparam logic [31:0] MISA_RESET = 32'h4000_0000  // mxl = rv32
                                       | (32'd1 << 0)   // A
                                       | (32'd1 << 2)   // C
                                       | (32'd1 << 4)   // E
                                       | (32'd1 << 6)   // G
                                       | (32'd1 << 8)   // I
                                       | (32'd1 << 12)  // M
                                       | (32'd1 << 18)  // S
                                       | (32'd1 << 20); // U

endpackage

/* design/stage_pkg.sv */
package stage_pkg;

    // datapath words
    typedef logic [31:0] xlen_data_t;
    typedef logic [31:0] pc_t;

    // csr number from the instruction immediate
    typedef logic [11:0] csr_addr_t;

    // exception code as delivered by earlier stages
    typedef logic [4:0] cause_t;

    // system operation decoded upstream
    typedef enum logic [2:0] {
        SYS_NONE      = 3'd0,
        SYS_ECALL     = 3'd1,
        SYS_EBREAK    = 3'd2,
        SYS_MRET      = 3'd3,
        SYS_SRET      = 3'd4,
        SYS_CSR_SWAP  = 3'd5,  // csrrw
        SYS_CSR_SET   = 3'd6,  // csrrs
        SYS_CSR_CLEAR = 3'd7   // csrrc
    } sys_op_t;

endpackage

/* design/trap_if.sv */
`timescale 1ns/1ps

interface trap_if;
    import riscv_priv_pkg::*;
    import stage_pkg::*;

    // decision side
    logic       take;       // trap entry this cycle
    logic       to_s;       // delegated to supervisor
    xlen_data_t cause;
    pc_t        epc;
    xlen_data_t tval;
    logic       mret;
    logic       sret;
    sys_op_t    csr_op;     // SYS_NONE unless a csr instruction
    csr_addr_t  csr_addr;
    xlen_data_t csr_wdata;

    // register file side
    priv_t      priv;
    xlen_data_t medeleg;
    xlen_data_t mtvec;
    xlen_data_t stvec;
    pc_t        mepc;
    pc_t        sepc;
    logic       isa_c;
    xlen_data_t csr_rdata;  // value before this cycle's write

    modport ctrl (
        output take, to_s, cause, epc, tval, mret, sret, csr_op, csr_addr, csr_wdata,
        input  priv, medeleg, mtvec, stvec, mepc, sepc, isa_c, csr_rdata
    );

    modport regs (
        input  take, to_s, cause, epc, tval, mret, sret, csr_op, csr_addr, csr_wdata,
        output priv, medeleg, mtvec, stvec, mepc, sepc, isa_c, csr_rdata
    );

endinterface

/* design/trap_ctrl.sv */
`timescale 1ns/1ps

module trap_ctrl (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_flush,
    input  logic                  i_valid,
    input  stage_pkg::pc_t        i_pc,
    input  logic                  i_except_valid,
    input  stage_pkg::cause_t     i_except_code,
    input  stage_pkg::xlen_data_t i_tval,
    input  stage_pkg::sys_op_t    i_sys_op,
    input  stage_pkg::csr_addr_t  i_csr_addr,
    input  stage_pkg::xlen_data_t i_data,
    trap_if.ctrl                  o_trap,
    output logic                  o_valid,
    output logic                  o_redirect,
    output stage_pkg::xlen_data_t o_data
);
    import riscv_priv_pkg::*;
    import stage_pkg::*;

    logic       live;
    logic       is_exc;
    logic       is_sys;
    logic       is_ecall;
    logic       is_ebreak;
    logic       is_mret;
    logic       is_sret;
    logic       is_csr;
    logic       take;
    logic       delegate;
    cause_t     ecall_code;
    cause_t     trap_code;
    xlen_data_t ret_mask;
    xlen_data_t next_data;

    // a flushed slot never reaches the register file
    assign live   = i_valid & ~i_flush;
    assign is_exc = live & i_except_valid;
    assign is_sys = live & ~i_except_valid;  // exceptions win over system ops

    assign is_ecall  = is_sys & (i_sys_op == SYS_ECALL);
    assign is_ebreak = is_sys & (i_sys_op == SYS_EBREAK);
    assign is_mret   = is_sys & (i_sys_op == SYS_MRET);
    assign is_sret   = is_sys & (i_sys_op == SYS_SRET);
    assign is_csr    = is_sys & (i_sys_op inside {SYS_CSR_SWAP, SYS_CSR_SET, SYS_CSR_CLEAR});

    always_comb begin
        case (o_trap.priv)
            PRIV_USER:       ecall_code = CAUSE_ECALL_U;
            PRIV_SUPERVISOR: ecall_code = CAUSE_ECALL_S;
            PRIV_MACHINE:    ecall_code = CAUSE_ECALL_M;
            default:         ecall_code = CAUSE_ECALL_M;
        endcase
    end

    assign take      = is_exc | is_ecall | is_ebreak;
    assign trap_code = is_exc ? i_except_code : (is_ecall ? ecall_code : CAUSE_BREAKPOINT);

    // ebreak always lands in machine mode
    assign delegate = ~is_ebreak & o_trap.medeleg[trap_code] &
                      ((o_trap.priv == PRIV_SUPERVISOR) | (o_trap.priv == PRIV_USER));

    assign o_trap.take      = take;
    assign o_trap.to_s      = take & delegate;
    assign o_trap.cause     = {27'd0, trap_code};
    assign o_trap.epc       = i_pc;
    assign o_trap.tval      = is_exc ? i_tval : (is_ebreak ? i_pc : '0);
    assign o_trap.mret      = is_mret;
    assign o_trap.sret      = is_sret;
    assign o_trap.csr_op    = is_csr ? i_sys_op : SYS_NONE;
    assign o_trap.csr_addr  = i_csr_addr;
    assign o_trap.csr_wdata = i_data;

    assign ret_mask = o_trap.isa_c ? 32'hffff_fffe : 32'hffff_fffc;  // align to 2 or 4 bytes

    always_comb begin
        if (take) begin
            next_data = delegate ? o_trap.stvec : o_trap.mtvec;
        end else if (is_mret) begin
            next_data = o_trap.mepc & ret_mask;
        end else if (is_sret) begin
            next_data = o_trap.sepc & ret_mask;
        end else if (is_csr) begin
            next_data = o_trap.csr_rdata;
        end else begin
            next_data = i_data;  // plain pass-through
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_flush) begin
            o_valid    <= 1'b0;
            o_redirect <= 1'b0;
            o_data     <= '0;
        end else begin
            o_valid    <= i_valid;
            o_redirect <= take | is_mret | is_sret;
            o_data     <= next_data;
        end
    end

endmodule

/* design/csr_file.sv */
`timescale 1ns/1ps

module csr_file (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    trap_if.regs                  i_trap,
    output stage_pkg::xlen_data_t o_satp
);
    import riscv_priv_pkg::*;
    import stage_pkg::*;

    priv_t       priv;
    xlen_data_t  status;    // mstatus and sstatus
    xlen_data_t  misa;
    xlen_data_t  medeleg;
    xlen_data_t  mtvec;
    xlen_data_t  mscratch;
    pc_t         mepc;
    xlen_data_t  mcause;
    xlen_data_t  mtval;
    xlen_data_t  stvec;
    xlen_data_t  sscratch;
    pc_t         sepc;
    xlen_data_t  scause;
    xlen_data_t  stval;
    xlen_data_t  satp;
    logic [63:0] cycle_cnt;

    xlen_data_t  rdata;
    xlen_data_t  wr_val;
    logic        csr_wr;

    function automatic xlen_data_t csr_update(input sys_op_t op, input xlen_data_t old,
                                              input xlen_data_t src);
        case (op)
            SYS_CSR_SWAP:  return src;
            SYS_CSR_SET:   return old | src;
            SYS_CSR_CLEAR: return old & ~src;
            default:       return old;
        endcase
    endfunction

    // trap entry into supervisor
    function automatic xlen_data_t enter_s(input xlen_data_t st, input priv_t cur);
        xlen_data_t r;
        r              = st;
        r[STATUS_SPP]  = cur[0];
        r[STATUS_SPIE] = st[STATUS_SIE];
        r[STATUS_SIE]  = 1'b0;
        return r;
    endfunction

    // trap entry into machine
    function automatic xlen_data_t enter_m(input xlen_data_t st, input priv_t cur);
        xlen_data_t r;
        r                     = st;
        r[STATUS_MPP_LO +: 2] = cur;
        r[STATUS_MPIE]        = st[STATUS_MIE];
        r[STATUS_MIE]         = 1'b0;
        return r;
    endfunction

    // read side gives the old value for the rd write
    always_comb begin
        case (i_trap.csr_addr)
            CSR_MSTATUS,
            CSR_SSTATUS:  rdata = status;
            CSR_MISA:     rdata = misa;
            CSR_MEDELEG:  rdata = medeleg;
            CSR_MTVEC:    rdata = mtvec;
            CSR_MSCRATCH: rdata = mscratch;
            CSR_MEPC:     rdata = mepc;
            CSR_MCAUSE:   rdata = mcause;
            CSR_MTVAL:    rdata = mtval;
            CSR_STVEC:    rdata = stvec;
            CSR_SSCRATCH: rdata = sscratch;
            CSR_SEPC:     rdata = sepc;
            CSR_SCAUSE:   rdata = scause;
            CSR_STVAL:    rdata = stval;
            CSR_SATP:     rdata = satp;
            CSR_CYCLE:    rdata = cycle_cnt[31:0];
            CSR_CYCLEH:   rdata = cycle_cnt[63:32];
            default:      rdata = '0;  // unmapped reads as zero
        endcase
    end

    assign csr_wr = (i_trap.csr_op != SYS_NONE);
    assign wr_val = csr_update(i_trap.csr_op, rdata, i_trap.csr_wdata);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            priv     <= PRIV_MACHINE;
            status   <= '0;
            misa     <= MISA_RESET;
            medeleg  <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            stvec    <= '0;
            sscratch <= '0;
            sepc     <= '0;
            scause   <= '0;
            stval    <= '0;
            satp     <= '0;
        end else if (i_trap.take) begin
            if (i_trap.to_s) begin
                sepc   <= i_trap.epc;
                scause <= i_trap.cause;
                stval  <= i_trap.tval;
                status <= enter_s(status, priv);
                priv   <= PRIV_SUPERVISOR;
            end else begin
                mepc   <= i_trap.epc;
                mcause <= i_trap.cause;
                mtval  <= i_trap.tval;
                status <= enter_m(status, priv);
                priv   <= PRIV_MACHINE;
            end
        end else if (i_trap.mret) begin
            status[STATUS_MIE] <= status[STATUS_MPIE];
            priv               <= status[STATUS_MPP_LO +: 2];
        end else if (i_trap.sret) begin
            status[STATUS_SIE] <= status[STATUS_SPIE];
            priv               <= {1'b0, status[STATUS_SPP]};
        end else if (csr_wr) begin
            case (i_trap.csr_addr)
                CSR_MSTATUS,
                CSR_SSTATUS:  status   <= wr_val;
                CSR_MISA:     misa     <= wr_val;
                CSR_MEDELEG:  medeleg  <= wr_val;
                CSR_MTVEC:    mtvec    <= wr_val;
                CSR_MSCRATCH: mscratch <= wr_val;
                CSR_MEPC:     mepc     <= wr_val;
                CSR_MCAUSE:   mcause   <= wr_val;
                CSR_MTVAL:    mtval    <= wr_val;
                CSR_STVEC:    stvec    <= wr_val;
                CSR_SSCRATCH: sscratch <= wr_val;
                CSR_SEPC:     sepc     <= wr_val;
                CSR_SCAUSE:   scause   <= wr_val;
                CSR_STVAL:    stval    <= wr_val;
                CSR_SATP:     satp     <= wr_val;
                default:      ;  // counters and unmapped are read only
            endcase
        end
    end

    // free running cycle counter
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 64'd1;
        end
    end

    assign i_trap.priv      = priv;
    assign i_trap.medeleg   = medeleg;
    assign i_trap.mtvec     = mtvec;
    assign i_trap.stvec     = stvec;
    assign i_trap.mepc      = mepc;
    assign i_trap.sepc      = sepc;
    assign i_trap.isa_c     = misa[MISA_C];
    assign i_trap.csr_rdata = rdata;

    assign o_satp = satp;

endmodule

/* design/csr_stage.sv */
`timescale 1ns/1ps

module csr_stage (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_flush,
    input  logic                  i_valid,
    input  stage_pkg::pc_t        i_pc,
    input  logic                  i_except_valid,
    input  stage_pkg::cause_t     i_except_code,
    input  stage_pkg::xlen_data_t i_tval,
    input  stage_pkg::sys_op_t    i_sys_op,
    input  stage_pkg::csr_addr_t  i_csr_addr,
    input  stage_pkg::xlen_data_t i_data,  // rs1 or earlier result
    output logic                  o_valid,
    output logic                  o_redirect,
    output stage_pkg::xlen_data_t o_data,
    output riscv_priv_pkg::priv_t o_priv,
    output logic                  o_isa_c,
    output stage_pkg::xlen_data_t o_satp
);

    trap_if trap_bus ();

    // decision and output register
    trap_ctrl u_trap_ctrl (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_flush        (i_flush),
        .i_valid        (i_valid),
        .i_pc           (i_pc),
        .i_except_valid (i_except_valid),
        .i_except_code  (i_except_code),
        .i_tval         (i_tval),
        .i_sys_op       (i_sys_op),
        .i_csr_addr     (i_csr_addr),
        .i_data         (i_data),
        .o_trap         (trap_bus.ctrl),
        .o_valid        (o_valid),
        .o_redirect     (o_redirect),
        .o_data         (o_data)
    );

    csr_file u_csr_file (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_trap  (trap_bus.regs),
        .o_satp  (o_satp)
    );

    assign o_priv  = trap_bus.priv;
    assign o_isa_c = trap_bus.isa_c;

endmodule

/* sim/csr_stage_props.sv */
`timescale 1ns/1ps

module csr_stage_props (
    input logic                  i_clk,
    input logic                  i_rst_n,
    input logic                  i_flush,
    input logic                  o_valid,
    input logic                  o_redirect,
    input riscv_priv_pkg::priv_t o_priv
);

    int fail_cnt = 0;  // failed assertion count

    // a jump only comes with a valid result
    redirect_has_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_redirect |-> o_valid)
        else begin
            fail_cnt++;
            $error("o_redirect high while o_valid is low");
        end

    // flushed slot never shows up at the outputs
    flush_clears_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_flush |=> !o_valid)
        else begin
            fail_cnt++;
            $error("o_valid still high one cycle after a flush");
        end

    priv_not_reserved: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_priv != 2'b10)
        else begin
            fail_cnt++;
            $error("o_priv holds the reserved level");
        end

endmodule

bind csr_stage csr_stage_props u_props (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_flush    (i_flush),
    .o_valid    (o_valid),
    .o_redirect (o_redirect),
    .o_priv     (o_priv)
);

/* sim/tb_csr_stage.sv */
`timescale 1ns/1ps

module tb_csr_stage;
    import riscv_priv_pkg::*;
    import stage_pkg::*;

    logic       i_clk;
    logic       i_rst_n;
    logic       i_flush;
    logic       i_valid;
    pc_t        i_pc;
    logic       i_except_valid;
    cause_t     i_except_code;
    xlen_data_t i_tval;
    sys_op_t    i_sys_op;
    csr_addr_t  i_csr_addr;
    xlen_data_t i_data;
    logic       o_valid;
    logic       o_redirect;
    xlen_data_t o_data;
    priv_t      o_priv;
    logic       o_isa_c;
    xlen_data_t o_satp;

    typedef struct packed {
        logic       valid;
        logic       redirect;
        logic       known;  // cleared for counter reads
        xlen_data_t data;
        priv_t      priv;
        logic       isa_c;
        xlen_data_t satp;
    } exp_t;

    xlen_data_t  m_csr [4096];  // model registers by csr number
    priv_t       m_priv;
    exp_t        pend;          // result of the slot driven last
    exp_t        cur;           // result now at the outputs
    logic [31:0] lcg_state = 32'h78b5;
    int          errors;
    logic        chk_en;

    csr_stage i_dut (.*);

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    function automatic xlen_data_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // returns {redirect, data} and steps the model state
    function automatic logic [32:0] ref_step(input logic flush, input logic valid,
                                             input logic exc, input cause_t code,
                                             input xlen_data_t tval, input sys_op_t op,
                                             input csr_addr_t addr, input xlen_data_t wdata,
                                             input pc_t pc);
        csr_addr_t  a;
        xlen_data_t st;
        xlen_data_t old;
        xlen_data_t align;
        cause_t     c;
        a     = (addr == CSR_SSTATUS) ? CSR_MSTATUS : addr;  // shared status
        st    = m_csr[CSR_MSTATUS];
        align = m_csr[CSR_MISA][MISA_C] ? 32'hffff_fffe : 32'hffff_fffc;
        if (flush)
            return '0;
        if (!valid)
            return {1'b0, wdata};
        if (exc || op == SYS_ECALL || op == SYS_EBREAK) begin
            if (exc)
                c = code;
            else if (op == SYS_EBREAK)
                c = CAUSE_BREAKPOINT;
            else
                c = (m_priv == PRIV_USER) ? CAUSE_ECALL_U :
                    (m_priv == PRIV_SUPERVISOR) ? CAUSE_ECALL_S : CAUSE_ECALL_M;
            if ((exc || op == SYS_ECALL) && m_priv != PRIV_MACHINE && m_csr[CSR_MEDELEG][c]) begin
                m_csr[CSR_SEPC]    = pc;
                m_csr[CSR_SCAUSE]  = {27'd0, c};
                m_csr[CSR_STVAL]   = exc ? tval : '0;
                st[STATUS_SPP]     = m_priv[0];
                st[STATUS_SPIE]    = st[STATUS_SIE];
                st[STATUS_SIE]     = 1'b0;
                m_csr[CSR_MSTATUS] = st;
                m_priv             = PRIV_SUPERVISOR;
                return {1'b1, m_csr[CSR_STVEC]};
            end
            m_csr[CSR_MEPC]        = pc;
            m_csr[CSR_MCAUSE]      = {27'd0, c};
            m_csr[CSR_MTVAL]       = exc ? tval : ((op == SYS_EBREAK) ? pc : '0);
            st[STATUS_MPP_LO +: 2] = m_priv;
            st[STATUS_MPIE]        = st[STATUS_MIE];
            st[STATUS_MIE]         = 1'b0;
            m_csr[CSR_MSTATUS]     = st;
            m_priv                 = PRIV_MACHINE;
            return {1'b1, m_csr[CSR_MTVEC]};
        end
        if (op == SYS_MRET) begin
            st[STATUS_MIE]     = st[STATUS_MPIE];
            m_priv             = st[STATUS_MPP_LO +: 2];
            m_csr[CSR_MSTATUS] = st;
            return {1'b1, m_csr[CSR_MEPC] & align};
        end
        if (op == SYS_SRET) begin
            st[STATUS_SIE]     = st[STATUS_SPIE];
            m_priv             = {1'b0, st[STATUS_SPP]};
            m_csr[CSR_MSTATUS] = st;
            return {1'b1, m_csr[CSR_SEPC] & align};
        end
        if (op inside {SYS_CSR_SWAP, SYS_CSR_SET, SYS_CSR_CLEAR}) begin
            old = m_csr[a];
            if (a inside {CSR_MSTATUS, CSR_MISA, CSR_MEDELEG, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC,
                          CSR_MCAUSE, CSR_MTVAL, CSR_STVEC, CSR_SSCRATCH, CSR_SEPC,
                          CSR_SCAUSE, CSR_STVAL, CSR_SATP})
                m_csr[a] = (op == SYS_CSR_SWAP) ? wdata :
                           (op == SYS_CSR_SET) ? (old | wdata) : (old & ~wdata);
            return {1'b0, old};
        end
        return {1'b0, wdata};
    endfunction

    task automatic check_val(input string name, input xlen_data_t got, input xlen_data_t exp);
        assert (got === exp) else begin
            errors++;
            $display("ERROR %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic drive(input logic flush, input logic valid, input logic exc,
                         input cause_t code, input xlen_data_t tval, input sys_op_t op,
                         input csr_addr_t addr, input xlen_data_t data, input pc_t pc);
        logic [32:0] r;
        @(negedge i_clk);
        i_flush        = flush;
        i_valid        = valid;
        i_except_valid = exc;
        i_except_code  = code;
        i_tval         = tval;
        i_sys_op       = op;
        i_csr_addr     = addr;
        i_data         = data;
        i_pc           = pc;
        r              = ref_step(flush, valid, exc, code, tval, op, addr, data, pc);
        pend.valid     = valid & ~flush;
        pend.redirect  = r[32];
        pend.data      = r[31:0];
        pend.known     = !(valid && !flush && !exc && op inside {SYS_CSR_SWAP, SYS_CSR_SET,
                           SYS_CSR_CLEAR} && addr inside {CSR_CYCLE, CSR_CYCLEH});
        pend.priv      = m_priv;
        pend.isa_c     = m_csr[CSR_MISA][MISA_C];
        pend.satp      = m_csr[CSR_SATP];
    endtask

    task automatic send_idle();
        drive(1'b0, 1'b0, 1'b0, '0, '0, SYS_NONE, '0, '0, '0);
    endtask

    task automatic send_csr(input sys_op_t op, input csr_addr_t addr, input xlen_data_t data,
                            input logic flush);
        drive(flush, 1'b1, 1'b0, '0, '0, op, addr, data, 32'h0000_1000);
    endtask

    task automatic send_sys(input sys_op_t op, input pc_t pc);
        drive(1'b0, 1'b1, 1'b0, '0, '0, op, '0, '0, pc);
    endtask

    task automatic send_exc(input cause_t code, input pc_t pc, input xlen_data_t tval);
        drive(1'b0, 1'b1, 1'b1, code, tval, SYS_NONE, '0, '0, pc);
    endtask

    task automatic wait_result(output logic redirect, output xlen_data_t data);
        logic seen;
        seen     = 1'b0;
        redirect = 1'b0;
        data     = '0;
        for (int n = 0; n < 8 && !seen; n++) begin
            send_idle();
            if (o_valid) begin
                seen     = 1'b1;
                redirect = o_redirect;
                data     = o_data;
            end
        end
        assert (seen) else begin
            errors++;
            $display("timed out waiting for a valid result at %0t", $time);
        end
    endtask

    task automatic read_csr(input csr_addr_t addr, output xlen_data_t data);
        logic redirect;
        send_csr(SYS_CSR_SET, addr, '0, 1'b0);  // set with zero is a pure read
        wait_result(redirect, data);
    endtask

    // outputs seen here belong to the slot sampled one edge earlier
    always @(posedge i_clk) begin
        if (chk_en) begin
            check_val("o_valid", {31'd0, o_valid}, {31'd0, cur.valid});
            check_val("o_redirect", {31'd0, o_redirect}, {31'd0, cur.redirect});
            if (cur.known)
                check_val("o_data", o_data, cur.data);
            check_val("o_priv", {30'd0, o_priv}, {30'd0, cur.priv});
            check_val("o_isa_c", {31'd0, o_isa_c}, {31'd0, cur.isa_c});
            check_val("o_satp", o_satp, cur.satp);
        end
        cur = pend;
    end

    initial begin
        xlen_data_t  d;
        xlen_data_t  d2;
        logic        rd;
        logic [31:0] r;
        sys_op_t     op;
        csr_addr_t   addr;
        i_rst_n        = 1'b0;
        i_flush        = 1'b0;
        i_valid        = 1'b0;
        i_pc           = '0;
        i_except_valid = 1'b0;
        i_except_code  = '0;
        i_tval         = '0;
        i_sys_op       = SYS_NONE;
        i_csr_addr     = '0;
        i_data         = '0;
        errors         = 0;
        chk_en         = 1'b0;
        m_priv         = PRIV_MACHINE;
        for (int k = 0; k < 4096; k++) begin
            m_csr[k] = '0;
        end
        m_csr[CSR_MISA] = MISA_RESET;
        cur             = '0;
        cur.known       = 1'b1;
        cur.priv        = PRIV_MACHINE;
        cur.isa_c       = 1'b1;
        pend            = cur;

        repeat (16) send_idle();
        i_rst_n = 1'b1;
        chk_en  = 1'b1;
        check_val("o_valid", {31'd0, o_valid}, 32'd0);
        check_val("o_priv", {30'd0, o_priv}, {30'd0, PRIV_MACHINE});
        check_val("o_isa_c", {31'd0, o_isa_c}, 32'd1);

        // random csr traffic with a read back after each op
        for (int k = 0; k < 16; k++) begin
            r = lcg_next();
            case (r[17:16])
                2'd0:    addr = CSR_MSCRATCH;
                2'd1:    addr = CSR_MTVEC;
                2'd2:    addr = CSR_STVEC;
                default: addr = CSR_SATP;
            endcase
            case (r[21:20])
                2'd0:    op = SYS_CSR_SET;
                2'd1:    op = SYS_CSR_CLEAR;
                default: op = SYS_CSR_SWAP;
            endcase
            send_csr(op, addr, lcg_next(), 1'b0);
            send_csr(SYS_CSR_SET, addr, '0, 1'b0);
        end
        read_csr(CSR_SATP, d);
        check_val("satp", d, m_csr[CSR_SATP]);
        check_val("o_satp", o_satp, m_csr[CSR_SATP]);
        read_csr(CSR_CYCLE, d);
        read_csr(CSR_CYCLE, d2);
        assert (d2 > d) else begin
            errors++;
            $display("cycle counter did not advance between two reads");
        end

        // machine trap and mret back to user
        send_csr(SYS_CSR_SWAP, CSR_MTVEC, 32'h0000_0100, 1'b0);
        send_exc(5'd5, 32'h0000_2000, 32'h0000_1234);
        wait_result(rd, d);
        check_val("o_redirect", {31'd0, rd}, 32'd1);
        check_val("o_data", d, 32'h0000_0100);
        read_csr(CSR_MCAUSE, d);
        check_val("mcause", d, 32'd5);
        send_csr(SYS_CSR_CLEAR, CSR_MSTATUS, 32'h0000_1800, 1'b0);  // mpp = user
        send_csr(SYS_CSR_SWAP, CSR_MEPC, 32'h0000_3007, 1'b0);
        send_sys(SYS_MRET, 32'h0000_2004);
        wait_result(rd, d);
        check_val("o_data", d, 32'h0000_3006);
        check_val("o_priv", {30'd0, o_priv}, {30'd0, PRIV_USER});

        // load page fault delegated to supervisor
        send_csr(SYS_CSR_SWAP, CSR_STVEC, 32'h0000_0400, 1'b0);
        send_csr(SYS_CSR_SET, CSR_MEDELEG, 32'h0000_2000, 1'b0);
        send_exc(5'd13, 32'h0000_4010, 32'hdead_0000);
        wait_result(rd, d);
        check_val("o_data", d, 32'h0000_0400);
        check_val("o_priv", {30'd0, o_priv}, {30'd0, PRIV_SUPERVISOR});
        send_sys(SYS_SRET, 32'h0000_0404);
        wait_result(rd, d);
        check_val("o_data", d, 32'h0000_4010);
        check_val("o_priv", {30'd0, o_priv}, {30'd0, PRIV_USER});

        // ecall from user, then ebreak
        send_sys(SYS_ECALL, 32'h0000_5000);
        wait_result(rd, d);
        check_val("o_data", d, 32'h0000_0100);
        read_csr(CSR_MCAUSE, d);
        check_val("mcause", d, 32'd8);
        send_sys(SYS_EBREAK, 32'h0000_5008);
        wait_result(rd, d);
        read_csr(CSR_MCAUSE, d);
        check_val("mcause", d, 32'd3);
        read_csr(CSR_MTVAL, d);
        check_val("mtval", d, 32'h0000_5008);

        // flushed write must not land
        read_csr(CSR_MSCRATCH, d);
        send_csr(SYS_CSR_SWAP, CSR_MSCRATCH, ~d, 1'b1);
        send_idle();
        check_val("o_valid", {31'd0, o_valid}, 32'd0);
        read_csr(CSR_MSCRATCH, d2);
        check_val("mscratch", d2, m_csr[CSR_MSCRATCH]);

        repeat (2) send_idle();
        $display("tb_csr_stage finished with %0d check errors and %0d assertion failures",
                 errors, i_dut.u_props.fail_cnt);
        if (errors == 0 && i_dut.u_props.fail_cnt == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

/* sources.f */
design/riscv_priv_pkg.sv
design/stage_pkg.sv
design/trap_if.sv
design/trap_ctrl.sv
design/csr_file.sv
design/csr_stage.sv
sim/csr_stage_props.sv
sim/tb_csr_stage.sv

/* Makefile */
TOP := tb_csr_stage

.PHONY: all run clean

all: run

obj_dir/V$(TOP): sources.f $(wildcard design/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f sources.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
